//--- all.f
hw/capture_pkg.sv
hw/spi_slave.sv
hw/sig_digitizer.sv
hw/nco.sv
hw/capture_ctrl.sv
hw/capture_top.sv
test/tb_clock_gen.sv
test/capture_tb.sv

//--- Bender.yml
package:
  name: capture

sources:
  - hw/capture_pkg.sv
  - hw/spi_slave.sv
  - hw/sig_digitizer.sv
  - hw/nco.sv
  - hw/capture_ctrl.sv
  - hw/capture_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/capture_tb.sv

//--- test/capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

module capture_tb
   import capture_pkg::*;
;

   localparam int SCK_HALF = 4;
   localparam int FRAME_GAP = 6;
   localparam int CAPTURE_WAIT = 4200;
   // rough frame count over all tests with waits counted as frames
   localparam longint FRAME_EST = 1500;
   localparam longint TIMEOUT_NS = 2 * FRAME_EST * 150 * 20;

   logic       clk;
   logic       rst;
   logic       spi_sck;
   logic       spi_ss;
   logic       spi_mosi;
   logic       lvds_in;
   logic       spi_miso;
   logic [2:0] led;

   logic [31:0] rng_state = 32'h46c6;
   int          checks = 0;
   int          errors = 0;
   int          tests = 0;
   int          errs_at_start = 0;
   logic [2:0]  exp_led;
   logic        exp_src;
   logic [15:0] got [512];
   logic [15:0] exp_mem [RAM_WORDS];

   tb_clock_gen u_clk (
      .clk (clk),
      .rst (rst)
   );

   capture_top u_dut (
      .clk      (clk),
      .rst      (rst),
      .spi_sck  (spi_sck),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .lvds_in  (lvds_in),
      .spi_miso (spi_miso),
      .led      (led)
   );

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state >> 8;
   endfunction

   function automatic logic [15:0] cmd_word(input opcode_e op, input logic [2:0] led_v,
                                            input logic start_v, input logic src_v);
      cmd_t c;
      c.rsvd    = '0;
      c.src_nco = src_v;
      c.start   = start_v;
      c.led     = led_v;
      c.opcode  = op;
      return c;
   endfunction

   function automatic logic [15:0] status_word(input logic done_v, input logic armed_v,
                                               input logic src_v, input logic [8:0] count);
      status_t s;
      s.done    = done_v;
      s.armed   = armed_v;
      s.src_nco = src_v;
      s.rsvd    = '0;
      s.count   = count;
      return s;
   endfunction

   // sample n after the clear is the top bit of n * step
   function automatic logic [15:0] nco_word(input int k);
      logic [15:0] w;
      logic [31:0] phase;
      int          j;
      w = '0;
      for (j = 0; j < SAMPLES_PER_WORD; j++) begin
         phase = (k * SAMPLES_PER_WORD + j) * NCO_STEP;
         w[15-j] = phase[15];
      end
      return w;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, actual, expected);
      end
   endtask

   // one mode-0 frame with MISO sampled on the falling clk edge before each SCK rise
   task automatic spi_xfer(input logic [15:0] tx, output logic [15:0] rx);
      int i;
      rx = '0;
      @(posedge clk);
      spi_ss   <= 1'b0;
      spi_mosi <= tx[15];
      for (i = 15; i >= 0; i--) begin
         repeat (SCK_HALF - 1) @(posedge clk);
         @(negedge clk);
         rx[i] = spi_miso;
         @(posedge clk);
         spi_sck <= 1'b1;
         repeat (SCK_HALF) @(posedge clk);
         spi_sck <= 1'b0;
         if (i > 0) begin
            spi_mosi <= tx[i-1];
         end
      end
      repeat (SCK_HALF) @(posedge clk);
      spi_ss   <= 1'b1;
      spi_mosi <= 1'b0;
      repeat (FRAME_GAP) @(posedge clk);
   endtask

   task automatic send_cmd(input logic [15:0] tx);
      logic [15:0] dummy;
      spi_xfer(tx, dummy);
   endtask

   task automatic read_status(output logic [15:0] s);
      send_cmd(cmd_word(op_status, 3'd0, 1'b0, 1'b0));
      spi_xfer(cmd_word(op_nop, 3'd0, 1'b0, 1'b0), s);
   endtask

   // each frame returns the word queued by the frame before
   task automatic read_words(input int n);
      logic [15:0] r;
      int          i;
      send_cmd(cmd_word(op_rewind, 3'd0, 1'b0, 1'b0));
      send_cmd(cmd_word(op_read, 3'd0, 1'b0, 1'b0));
      for (i = 0; i < n; i++) begin
         if (i == n - 1) begin
            spi_xfer(cmd_word(op_nop, 3'd0, 1'b0, 1'b0), r);
         end else begin
            spi_xfer(cmd_word(op_read, 3'd0, 1'b0, 1'b0), r);
         end
         got[i] = r;
      end
   endtask

   task automatic start_capture(input logic src_v);
      exp_led = next_random() % 8;
      exp_src = src_v;
      send_cmd(cmd_word(op_config, exp_led, 1'b1, src_v));
   endtask

   task automatic check_done();
      logic [15:0] s;
      read_status(s);
      check_value("status", s, status_word(1'b1, 1'b0, exp_src, 9'd256));
      @(negedge clk);
      check_value("led", led, exp_led);
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("test %-18s %s (%0d errors)", name,
               (errors == errs_at_start) ? "ok" : "FAIL", errors - errs_at_start);
      errs_at_start = errors;
   endtask

   task automatic test_reset_leds();
      logic [15:0] s;
      int          i;
      @(negedge clk);
      check_value("led", led, 3'd0);
      read_status(s);
      check_value("status", s, 16'h0000);
      for (i = 0; i < 8; i++) begin
         exp_led = next_random() % 8;
         exp_src = next_random() % 2;
         send_cmd(cmd_word(op_config, exp_led, 1'b0, exp_src));
         @(negedge clk);
         check_value("led", led, exp_led);
         read_status(s);
         check_value("status", s, status_word(1'b0, 1'b0, exp_src, 9'd0));
      end
      finish_test("reset and leds");
   endtask

   task automatic test_nco_capture();
      int k;
      start_capture(1'b1);
      repeat (CAPTURE_WAIT) @(posedge clk);
      check_done();
      read_words(RAM_WORDS);
      for (k = 0; k < RAM_WORDS; k++) begin
         exp_mem[k] = nco_word(k);
         check_value($sformatf("ram word %0d", k), got[k], exp_mem[k]);
      end
      finish_test("nco capture");
   endtask

   task automatic test_read_pointer();
      logic [15:0] r;
      int          n;
      int          i;
      n = 1 + int'(next_random() % 20);
      send_cmd(cmd_word(op_rewind, 3'd0, 1'b0, 1'b0));
      for (i = 0; i < n; i++) begin
         send_cmd(cmd_word(op_read, 3'd0, 1'b0, 1'b0));
      end
      send_cmd(cmd_word(op_rewind, 3'd0, 1'b0, 1'b0));
      send_cmd(cmd_word(op_read, 3'd0, 1'b0, 1'b0));
      spi_xfer(cmd_word(op_nop, 3'd0, 1'b0, 1'b0), r);
      check_value("word after rewind", r, exp_mem[0]);
      read_words(RAM_WORDS + 1);
      for (i = 0; i <= RAM_WORDS; i++) begin
         check_value($sformatf("ram word %0d", i), got[i], exp_mem[i % RAM_WORDS]);
      end
      finish_test("read pointer");
   endtask

   task automatic test_level_capture();
      int          k;
      int          pass;
      logic [15:0] exp_w;
      for (pass = 0; pass < 2; pass++) begin
         exp_w = (pass == 0) ? 16'hffff : 16'h0000;
         @(posedge clk);
         lvds_in <= (pass == 0);
         repeat (10) @(posedge clk);
         start_capture(1'b0);
         repeat (CAPTURE_WAIT) @(posedge clk);
         check_done();
         read_words(RAM_WORDS);
         // word 0 can still hold the filter latency
         for (k = 1; k < RAM_WORDS; k++) begin
            check_value($sformatf("ram word %0d", k), got[k], exp_w);
         end
      end
      finish_test("level capture");
   endtask

   task automatic test_glitch_reject();
      int k;
      int cyc;
      int gap;
      @(posedge clk);
      lvds_in <= 1'b0;
      start_capture(1'b0);
      cyc = 0;
      while (cyc < CAPTURE_WAIT) begin
         @(posedge clk);
         lvds_in <= 1'b1;
         @(posedge clk);
         lvds_in <= 1'b0;
         gap = 3 + int'(next_random() % 6);
         repeat (gap) @(posedge clk);
         cyc += gap + 2;
      end
      check_done();
      read_words(RAM_WORDS);
      for (k = 1; k < RAM_WORDS; k++) begin
         check_value($sformatf("ram word %0d", k), got[k], 16'h0000);
      end
      finish_test("glitch rejection");
   endtask

   task automatic test_nop_empty();
      logic [15:0] r;
      logic [15:0] s;
      send_cmd(cmd_word(op_nop, 3'd0, 1'b0, 1'b0));
      spi_xfer(cmd_word(op_nop, 3'd0, 1'b0, 1'b0), r);
      check_value("miso after nop", r, 16'h0000);
      @(negedge clk);
      check_value("led", led, exp_led);
      exp_led = next_random() % 8;
      send_cmd(cmd_word(op_config, exp_led, 1'b0, exp_src));
      spi_xfer(cmd_word(op_nop, 3'd0, 1'b0, 1'b0), r);
      check_value("miso after config", r, 16'h0000);
      @(negedge clk);
      check_value("led", led, exp_led);
      read_status(s);
      check_value("status", s, status_word(1'b1, 1'b0, exp_src, 9'd256));
      finish_test("nop and empty");
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog: simulation did not finish in %0d ns", TIMEOUT_NS);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      spi_sck  = 1'b0;
      spi_ss   = 1'b1;
      spi_mosi = 1'b0;
      lvds_in  = 1'b0;
      wait (rst === 1'b0);
      repeat (2) @(posedge clk);
      test_reset_leds();
      test_nco_capture();
      test_read_pointer();
      test_level_capture();
      test_glitch_reject();
      test_nop_empty();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // reset held for 8 rising edges
   initial begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

//--- hw/capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module capture_top
   import capture_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       spi_sck,
   input  logic       spi_ss,
   input  logic       spi_mosi,
   input  logic       lvds_in,
   output logic       spi_miso,
   output logic [2:0] led
);

   logic                  rx_valid;
   logic                  rx_ack;
   cmd_t                  rx_cmd;
   logic                  tx_free;
   logic                  tx_load;
   logic [FRAME_BITS-1:0] tx_data;
   logic                  sig;
   logic                  tone;
   logic                  nco_clear;

   spi_slave u_spi (
      .clk      (clk),
      .rst      (rst),
      .spi_sck  (spi_sck),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso),
      .rx_valid (rx_valid),
      .rx_data  (rx_cmd),
      .rx_ack   (rx_ack),
      .tx_free  (tx_free),
      .tx_load  (tx_load),
      .tx_data  (tx_data)
   );

   sig_digitizer u_dig (
      .clk     (clk),
      .rst     (rst),
      .lvds_in (lvds_in),
      .sig     (sig)
   );

   // tone phase restarts with every armed capture
   nco u_nco (
      .clk   (clk),
      .rst   (rst),
      .clear (nco_clear),
      .tone  (tone)
   );

   capture_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .rx_valid  (rx_valid),
      .rx_data   (rx_cmd),
      .rx_ack    (rx_ack),
      .tx_free   (tx_free),
      .tx_load   (tx_load),
      .tx_data   (tx_data),
      .sig       (sig),
      .tone      (tone),
      .nco_clear (nco_clear),
      .led       (led)
   );

endmodule

`default_nettype wire

//--- hw/capture_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl
   import capture_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  rx_valid,
   input  cmd_t                  rx_data,
   output logic                  rx_ack,
   input  logic                  tx_free,
   output logic                  tx_load,
   output logic [FRAME_BITS-1:0] tx_data,
   input  logic                  sig,
   input  logic                  tone,
   output logic                  nco_clear,
   output logic [2:0]            led
);

   logic                                armed;
   logic                                done;
   logic                                src_nco;
   logic [RAM_AW:0]                     word_cnt;
   logic [$clog2(SAMPLES_PER_WORD)-1:0] samp_cnt;
   logic [SAMPLES_PER_WORD-1:0]         packer;
   logic                                sample;
   logic                                word_full;
   logic [RAM_AW-1:0]                   rd_ptr;
   logic [SAMPLES_PER_WORD-1:0]         ram [RAM_WORDS];
   logic [SAMPLES_PER_WORD-1:0]         ram_q;
   logic                                tx_is_status;
   logic                                is_config;
   logic                                is_read;
   logic                                is_rewind;
   logic                                is_status;
   logic                                start_cmd;
   logic                                can_queue;
   status_t                             status;

   // each command is consumed the cycle it shows up
   assign rx_ack    = rx_valid;
   assign is_config = rx_valid && (rx_data.opcode == op_config);
   assign is_read   = rx_valid && (rx_data.opcode == op_read);
   assign is_rewind = rx_valid && (rx_data.opcode == op_rewind);
   assign is_status = rx_valid && (rx_data.opcode == op_status);
   assign start_cmd = is_config && rx_data.start;
   assign can_queue = (is_read || is_status) && tx_free;
   assign nco_clear = start_cmd;

   assign sample    = src_nco ? tone : sig;
   assign word_full = armed && (int'(samp_cnt) == SAMPLES_PER_WORD - 1);

   assign status = '{done: done, armed: armed, src_nco: src_nco, rsvd: '0, count: word_cnt};

   always_ff @(posedge clk) begin
      if (rst) begin
         led          <= '0;
         src_nco      <= 1'b0;
         armed        <= 1'b0;
         done         <= 1'b0;
         word_cnt     <= '0;
         samp_cnt     <= '0;
         rd_ptr       <= '0;
         tx_load      <= 1'b0;
         tx_is_status <= 1'b0;
      end else begin
         tx_load <= 1'b0;
         if (armed) begin
            samp_cnt <= samp_cnt + 1'b1;
            if (word_full) begin
               word_cnt <= word_cnt + 1'b1;
               // last word of the buffer ends the capture
               if (int'(word_cnt) == RAM_WORDS - 1) begin
                  armed <= 1'b0;
                  done  <= 1'b1;
               end
            end
         end
         if (is_config) begin
            led     <= rx_data.led;
            src_nco <= rx_data.src_nco;
         end
         // restart overrides a capture in progress
         if (start_cmd) begin
            armed    <= 1'b1;
            done     <= 1'b0;
            word_cnt <= '0;
            samp_cnt <= '0;
         end
         if (can_queue) begin
            tx_load      <= 1'b1;
            tx_is_status <= is_status;
         end
         if (is_read && tx_free) begin
            rd_ptr <= rd_ptr + 1'b1;
         end else if (is_rewind) begin
            rd_ptr <= '0;
         end
      end
   end

   // packer shifts every cycle, earliest sample ends up in the msb
   always_ff @(posedge clk) begin
      packer <= {packer[SAMPLES_PER_WORD-2:0], sample};
      if (word_full) begin
         ram[word_cnt[RAM_AW-1:0]] <= {packer[SAMPLES_PER_WORD-2:0], sample};
      end
      if (is_read && tx_free) begin
         ram_q <= ram[rd_ptr];
      end
   end

   assign tx_data = tx_is_status ? FRAME_BITS'(status) : ram_q;

endmodule

`default_nettype wire

//--- hw/nco.sv
`timescale 1ns/1ps
`default_nettype none

module nco
   import capture_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic clear,
   output logic tone
);

   logic [NCO_W-1:0] phase;

   // phase accumulator, clear restarts the tone at phase zero
   always_ff @(posedge clk) begin
      if (rst || clear) begin
         phase <= '0;
      end else begin
         phase <= phase + NCO_STEP;
      end
   end

   assign tone = phase[NCO_W-1];

endmodule

`default_nettype wire

//--- hw/sig_digitizer.sv
`timescale 1ns/1ps
`default_nettype none

module sig_digitizer (
   input  logic clk,
   input  logic rst,
   input  logic lvds_in,
   output logic sig
);

   logic [1:0] sync;
   logic [1:0] hist;

   always_ff @(posedge clk) begin
      if (rst) begin
         sync <= '0;
         hist <= '0;
         sig  <= 1'b0;
      end else begin
         sync <= {sync[0], lvds_in};
         hist <= {hist[0], sync[1]};
         // 2 of 3 vote, a lone one-cycle pulse never wins
         sig  <= (sync[1] & hist[0]) | (sync[1] & hist[1]) | (hist[0] & hist[1]);
      end
   end

endmodule

`default_nettype wire

//--- hw/spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave
   import capture_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  spi_sck,
   input  logic                  spi_ss,
   input  logic                  spi_mosi,
   output logic                  spi_miso,
   output logic                  rx_valid,
   output logic [FRAME_BITS-1:0] rx_data,
   input  logic                  rx_ack,
   output logic                  tx_free,
   input  logic                  tx_load,
   input  logic [FRAME_BITS-1:0] tx_data
);

   // pin synchronisers, the third sck/ss stage is only for edge detection
   logic [2:0] sck_pipe;
   logic [2:0] ss_pipe;
   logic [1:0] mosi_pipe;
   logic       sck_rise;
   logic       sck_fall;
   logic       ss_fall;
   logic       ss_active;
   logic       last_bit;

   logic [$clog2(FRAME_BITS)-1:0] bit_cnt;
   logic [FRAME_BITS-1:0]         rx_shift;
   logic [FRAME_BITS-1:0]         tx_shift;
   logic [FRAME_BITS-1:0]         tx_buf;
   logic                          tx_full;

   always_ff @(posedge clk) begin
      if (rst) begin
         sck_pipe  <= '0;
         ss_pipe   <= '1;
         mosi_pipe <= '0;
      end else begin
         sck_pipe  <= {sck_pipe[1:0], spi_sck};
         ss_pipe   <= {ss_pipe[1:0], spi_ss};
         mosi_pipe <= {mosi_pipe[0], spi_mosi};
      end
   end

   assign sck_rise  = sck_pipe[1] & ~sck_pipe[2];
   assign sck_fall  = ~sck_pipe[1] & sck_pipe[2];
   assign ss_fall   = ~ss_pipe[1] & ss_pipe[2];
   assign ss_active = ~ss_pipe[1];
   assign last_bit  = (int'(bit_cnt) == FRAME_BITS - 1);

   // bit counter and receive handshake
   always_ff @(posedge clk) begin
      if (rst) begin
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         if (rx_ack) begin
            rx_valid <= 1'b0;
         end
         if (!ss_active) begin
            bit_cnt <= '0;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            // a new frame wins over an unacknowledged one
            if (last_bit) begin
               rx_valid <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ss_active && sck_rise) begin
         rx_shift <= {rx_shift[FRAME_BITS-2:0], mosi_pipe[1]};
         if (last_bit) begin
            rx_data <= {rx_shift[FRAME_BITS-2:0], mosi_pipe[1]};
         end
      end
   end

   // transmit side, buffer is handed to the shifter at frame start
   always_ff @(posedge clk) begin
      if (rst) begin
         tx_full  <= 1'b0;
         tx_shift <= '0;
      end else begin
         if (ss_fall) begin
            tx_shift <= tx_full ? tx_buf : '0;
            tx_full  <= 1'b0;
         end else if (ss_active && sck_fall) begin
            tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
         end
         if (tx_load) begin
            tx_full <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_load) begin
         tx_buf <= tx_data;
      end
   end

   assign tx_free  = ~tx_full;
   assign spi_miso = tx_shift[FRAME_BITS-1];

endmodule

`default_nettype wire

//--- hw/capture_pkg.sv
`default_nettype none

package capture_pkg;

   // spi framing
   localparam int FRAME_BITS = 16;

   // capture geometry
   localparam int SAMPLES_PER_WORD = 16;
   localparam int RAM_WORDS = 256;
   localparam int RAM_AW = 8;

   // self-test tone
   localparam int NCO_W = 16;
   localparam logic [NCO_W-1:0] NCO_STEP = 16'h2100;

   typedef enum logic [7:0] {
      op_nop    = 8'h00,
      op_config = 8'h01,
      op_read   = 8'h02,
      op_rewind = 8'h03,
      op_status = 8'h04
   } opcode_e;

   // arguments in the high byte, opcode in the low byte
   typedef struct packed {
      logic [2:0] rsvd;
      logic       src_nco;
      logic       start;
      logic [2:0] led;
      opcode_e    opcode;
   } cmd_t;

   typedef struct packed {
      logic          done;
      logic          armed;
      logic          src_nco;
      logic [3:0]    rsvd;
      logic [RAM_AW:0] count;
   } status_t;

endpackage

`default_nettype wire
